/* rtl/timer_consts.svh */
// Counter width, AXI4-Lite bus widths and register byte offsets for the interval timer
`ifndef TIMER_CONSTS_SVH
`define TIMER_CONSTS_SVH

// Width of the ext_clk counter and of the captured result
`define TIMER_WIDTH 20

// AXI4-Lite bus geometry
`define AXI_ADDR_W 4
`define AXI_DATA_W 32

// Register map, byte offsets
// CTRL: bit 0 start, bit 1 stop, reads as zero
`define REG_CTRL 4'h0

// STATUS: busy and sticky done
`define REG_STATUS 4'h4

// RESULT: last captured interval, zero-extended
`define REG_RESULT 4'h8

`endif

/* rtl/timer_pkg.sv */
// Shared types for the interval timer: count type, core state, AXI response and status word
`include "timer_consts.svh"

package timer_pkg;

    // Counter and captured interval
    typedef logic [`TIMER_WIDTH-1:0] count_t;

    // States of the ext_clk measurement FSM
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        COUNTING = 2'b01,
        CAPTURE  = 2'b10
    } timer_state_e;

    // AXI4-Lite response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // STATUS register layout
    typedef struct packed {
        logic [29:0] reserved;
        // Set on capture, cleared by a RESULT read
        logic        done;
        // Timer is counting, as seen in sys_clk
        logic        busy;
    } status_t;

endpackage

/* rtl/timer_cdc_if.sv */
// Clock-crossing bundle between the sys_clk register block and the ext_clk timing core
`timescale 1ns/1ps

interface timer_cdc_if;

    // Commands, each inverts once per accepted write
    logic start_tgl;
    logic stop_tgl;

    // Status and results from the core
    logic              busy;
    logic              done_tgl;
    timer_pkg::count_t elapsed;

    // Register side in sys_clk
    modport regs (
        output start_tgl,
        output stop_tgl,
        input  busy,
        input  done_tgl,
        input  elapsed
    );

    // Timing core in ext_clk
    modport core (
        input  start_tgl,
        input  stop_tgl,
        output busy,
        output done_tgl,
        output elapsed
    );

endinterface

/* rtl/timer_regs.sv */
// AXI4-Lite slave with CTRL, STATUS and RESULT registers and sys_clk synchronizers
`timescale 1ns/1ps
`include "timer_consts.svh"

module timer_regs (
    input  logic                     sys_clk,
    input  logic                     rst_n,
    input  logic [`AXI_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic [`AXI_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`AXI_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    timer_cdc_if.regs                cdc
);
    logic                    wr_accept;
    logic                    rd_accept;
    logic                    wr_ctrl;
    logic                    rd_result;
    logic                    start_tgl_q;
    logic                    stop_tgl_q;
    logic [1:0]              busy_sync_q;
    logic [1:0]              done_sync_q;
    logic                    done_seen_q;
    logic                    done_edge;
    logic                    done_q;
    logic [`TIMER_WIDTH-1:0] result_q;
    timer_pkg::status_t      status;

    // Accept only when no response of the same kind is outstanding
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    assign wr_ctrl   = wr_accept && (awaddr == `REG_CTRL);
    assign rd_result = rd_accept && (araddr == `REG_RESULT);

    // Start and stop requests become toggles, start wins
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            start_tgl_q <= 1'b0;
            stop_tgl_q  <= 1'b0;
        end else if (wr_ctrl) begin
            if (wdata[0]) begin
                start_tgl_q <= ~start_tgl_q;
            end else if (wdata[1]) begin
                stop_tgl_q <= ~stop_tgl_q;
            end
        end
    end

    assign cdc.start_tgl = start_tgl_q;
    assign cdc.stop_tgl  = stop_tgl_q;

    // Two-flop synchronizers for the returning core signals
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_sync_q <= 2'b00;
            done_sync_q <= 2'b00;
            done_seen_q <= 1'b0;
        end else begin
            busy_sync_q <= {busy_sync_q[0], cdc.busy};
            done_sync_q <= {done_sync_q[0], cdc.done_tgl};
            done_seen_q <= done_sync_q[1];
        end
    end

    // A change of done_tgl means elapsed has settled
    assign done_edge = done_sync_q[1] ^ done_seen_q;

    // Sticky done and result capture; a new capture beats a clearing read
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            if (done_edge) begin
                done_q   <= 1'b1;
                result_q <= cdc.elapsed;
            end else if (rd_result) begin
                done_q <= 1'b0;
            end
        end
    end

    always_comb begin
        status      = '0;
        status.busy = busy_sync_q[1];
        status.done = done_q;
    end

    // Response handshakes, held until the master takes them
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge sys_clk) begin
        if (wr_accept) begin
            bresp <= wr_ctrl ? timer_pkg::OKAY : timer_pkg::SLVERR;
        end
        if (rd_accept) begin
            rresp <= timer_pkg::OKAY;
            case (araddr)
                `REG_CTRL:   rdata <= '0;
                `REG_STATUS: rdata <= status;
                `REG_RESULT: rdata <= {{(`AXI_DATA_W-`TIMER_WIDTH){1'b0}}, result_q};
                default: begin
                    rdata <= '0;
                    rresp <= timer_pkg::SLVERR;
                end
            endcase
        end
    end

endmodule

/* rtl/timer_core.sv */
// ext_clk timing core: command synchronizers, measurement FSM, counter and capture register
`timescale 1ns/1ps

module timer_core (
    input  logic      ext_clk,
    input  logic      rst_n,
    timer_cdc_if.core cdc
);
    logic [1:0]              start_sync_q;
    logic [1:0]              stop_sync_q;
    logic                    start_seen_q;
    logic                    stop_seen_q;
    logic                    start_pulse;
    logic                    stop_pulse;
    timer_pkg::timer_state_e state_q;
    timer_pkg::timer_state_e state_d;
    timer_pkg::count_t       count_q;
    timer_pkg::count_t       elapsed_q;
    logic                    done_tgl_q;
    logic                    busy_q;

    // Bring the command toggles into ext_clk
    always_ff @(posedge ext_clk or negedge rst_n) begin
        if (!rst_n) begin
            start_sync_q <= 2'b00;
            stop_sync_q  <= 2'b00;
            start_seen_q <= 1'b0;
            stop_seen_q  <= 1'b0;
        end else begin
            start_sync_q <= {start_sync_q[0], cdc.start_tgl};
            stop_sync_q  <= {stop_sync_q[0], cdc.stop_tgl};
            start_seen_q <= start_sync_q[1];
            stop_seen_q  <= stop_sync_q[1];
        end
    end

    // One-cycle pulse per toggle change
    assign start_pulse = start_sync_q[1] ^ start_seen_q;
    assign stop_pulse  = stop_sync_q[1] ^ stop_seen_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            timer_pkg::IDLE: begin
                if (start_pulse) begin
                    state_d = timer_pkg::COUNTING;
                end
            end
            timer_pkg::COUNTING: begin
                if (stop_pulse) begin
                    state_d = timer_pkg::CAPTURE;
                end
            end
            timer_pkg::CAPTURE: state_d = timer_pkg::IDLE;
            default:            state_d = timer_pkg::IDLE;
        endcase
    end

    always_ff @(posedge ext_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= timer_pkg::IDLE;
            busy_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_q  <= (state_d == timer_pkg::COUNTING);
        end
    end

    // Counter restarts on start and wraps freely while counting
    always_ff @(posedge ext_clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (state_q == timer_pkg::IDLE && start_pulse) begin
            count_q <= '0;
        end else if (state_q == timer_pkg::COUNTING) begin
            count_q <= count_q + 1'b1;
        end
    end

    // elapsed and done_tgl change on the same edge, so the sys_clk side
    // can sample elapsed once it sees the toggle
    always_ff @(posedge ext_clk or negedge rst_n) begin
        if (!rst_n) begin
            elapsed_q  <= '0;
            done_tgl_q <= 1'b0;
        end else if (state_q == timer_pkg::COUNTING && stop_pulse) begin
            elapsed_q  <= count_q;
            done_tgl_q <= ~done_tgl_q;
        end
    end

    assign cdc.busy     = busy_q;
    assign cdc.elapsed  = elapsed_q;
    assign cdc.done_tgl = done_tgl_q;

endmodule

/* rtl/timer_top.sv */
// Top level of the interval timer: register block and timing core joined by the CDC bundle
`timescale 1ns/1ps
`include "timer_consts.svh"

module timer_top (
    input  logic                     ext_clk,
    input  logic                     sys_clk,
    input  logic                     rst_n,
    input  logic [`AXI_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic [`AXI_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`AXI_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);
    timer_cdc_if cdc ();

    // Bus side, sys_clk
    timer_regs u_regs (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cdc     (cdc.regs)
    );

    // Measured side, ext_clk
    timer_core u_core (
        .ext_clk (ext_clk),
        .rst_n   (rst_n),
        .cdc     (cdc.core)
    );

endmodule

/* sim/tb_timer.sv */
// Testbench for the interval timer: clocks, reset, LFSR stimulus, AXI tasks, model and checks
`timescale 1ns/1ps
`include "timer_consts.svh"

module tb_timer;

    localparam int NUM_MEAS = 20;
    localparam int MIN_GAP  = 5;
    localparam int MAX_GAP  = 300;
    // Each measurement also spends cycles on status polling and result reads
    localparam int LIMIT    = NUM_MEAS * (MAX_GAP + 100) + 2000;

    logic                     ext_clk;
    logic                     sys_clk;
    logic                     rst_n;
    logic [`AXI_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`AXI_DATA_W-1:0]   wdata;
    logic [`AXI_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`AXI_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`AXI_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;

    int                ext_edges;
    logic [15:0]       lfsr_q;
    // Reference model
    logic              model_done;
    logic              model_running;
    timer_pkg::count_t model_result;

    timer_top i_dut (.*);

    initial begin
        ext_clk = 1'b0;
        forever #10 ext_clk = ~ext_clk;
    end

    initial begin
        sys_clk = 1'b0;
        forever #7 sys_clk = ~sys_clk;
    end

    // Free-running count of ext_clk edges for the model and the timeout
    initial begin
        ext_edges = 0;
    end

    always @(posedge ext_clk) begin
        ext_edges <= ext_edges + 1;
        if (ext_edges >= LIMIT) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout: the run did not finish within %0d ext_clk cycles", LIMIT);
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic mismatch(input string msg);
        timer_pkg::timer_state_e st;
        st = i_dut.u_core.state_q;
        $display("CHECK FAILED at %0t ns: %s (core state %s)", $time, msg, st.name());
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic protocol_error(input string msg);
        $display("Bus protocol error at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping on a bus protocol error");
    endtask

    task automatic check_resp(input timer_pkg::axi_resp_e got, input timer_pkg::axi_resp_e exp,
                              input string what);
        if (got !== exp) begin
            mismatch($sformatf("%s: response %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_status(input timer_pkg::status_t got, input timer_pkg::status_t exp,
                                input string what);
        if (got !== exp) begin
            mismatch($sformatf("%s: STATUS 0x%08h, expected 0x%08h", what, got, exp));
        end
    endtask

    task automatic check_result(input timer_pkg::count_t got, input timer_pkg::count_t exp,
                                input int tol, input string what);
        int diff;
        diff = int'(got) - int'(exp);
        if (diff > tol || diff < -tol) begin
            mismatch($sformatf("%s: RESULT %0d, expected %0d +/- %0d", what, got, exp, tol));
        end
    endtask

    task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             output timer_pkg::axi_resp_e resp, output int stamp);
        int delay;
        @(negedge sys_clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            if (awready !== wready) begin
                protocol_error("awready and wready did not rise together");
            end
            @(negedge sys_clk);
            #1;
        end
        // The handshake edge is the time reference of the command
        @(posedge sys_clk);
        stamp = ext_edges;
        @(negedge sys_clk);
        if (awready || wready) begin
            protocol_error("write ready stayed high while its response was pending");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        delay = rand_bits(2);
        repeat (delay) @(negedge sys_clk);
        bready = 1'b1;
        while (!bvalid) @(negedge sys_clk);
        resp = timer_pkg::axi_resp_e'(bresp);
        @(negedge sys_clk);
        bready = 1'b0;
        if (bvalid) begin
            protocol_error("write response repeated after its handshake");
        end
    endtask

    task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                            output timer_pkg::axi_resp_e resp);
        int delay;
        @(negedge sys_clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge sys_clk);
            #1;
        end
        @(negedge sys_clk);
        if (arready) begin
            protocol_error("read ready stayed high while its response was pending");
        end
        arvalid = 1'b0;
        delay = rand_bits(2);
        repeat (delay) @(negedge sys_clk);
        rready = 1'b1;
        while (!rvalid) @(negedge sys_clk);
        data = rdata;
        resp = timer_pkg::axi_resp_e'(rresp);
        @(negedge sys_clk);
        rready = 1'b0;
        if (rvalid) begin
            protocol_error("read response repeated after its handshake");
        end
    endtask

    function automatic timer_pkg::status_t model_status();
        timer_pkg::status_t s;
        s      = '0;
        s.busy = model_running;
        s.done = model_done;
        return s;
    endfunction

    task automatic wait_ext_until(input int edge_no);
        while (ext_edges < edge_no) @(posedge ext_clk);
    endtask

    // Read STATUS and RESULT and compare both against the model
    task automatic check_idle_state(input string what);
        timer_pkg::axi_resp_e resp;
        logic [31:0]          data;
        axi_read(`REG_STATUS, data, resp);
        check_resp(resp, timer_pkg::OKAY, {what, " STATUS read"});
        check_status(timer_pkg::status_t'(data), model_status(), what);
        axi_read(`REG_RESULT, data, resp);
        check_resp(resp, timer_pkg::OKAY, {what, " RESULT read"});
        check_result(data[`TIMER_WIDTH-1:0], model_result, 0, what);
        if (data[31:`TIMER_WIDTH] != '0) mismatch({what, ": RESULT upper bits not zero"});
    endtask

    task automatic measure(input int n);
        timer_pkg::axi_resp_e resp;
        logic [31:0]          data;
        timer_pkg::status_t   st;
        int                   gap;
        int                   t_start;
        int                   t_stop;
        int                   t_dummy;
        gap = MIN_GAP + rand_bits(9) % (MAX_GAP - MIN_GAP + 1);
        axi_write(`REG_CTRL, 32'h1, resp, t_start);
        check_resp(resp, timer_pkg::OKAY, "start write");
        model_running = 1'b1;
        if (gap >= 60) begin
            wait_ext_until(t_start + 20);
            axi_read(`REG_STATUS, data, resp);
            check_resp(resp, timer_pkg::OKAY, "STATUS read while counting");
            check_status(timer_pkg::status_t'(data), model_status(), "busy while counting");
            // A repeated start must not restart the count
            if (rand_bits(1) == 1) begin
                axi_write(`REG_CTRL, 32'h1, resp, t_dummy);
                check_resp(resp, timer_pkg::OKAY, "second start write");
            end
        end
        wait_ext_until(t_start + gap);
        axi_write(`REG_CTRL, 32'h2, resp, t_stop);
        check_resp(resp, timer_pkg::OKAY, "stop write");
        model_running = 1'b0;
        do begin
            axi_read(`REG_STATUS, data, resp);
            check_resp(resp, timer_pkg::OKAY, "STATUS poll");
            st = timer_pkg::status_t'(data);
        end while (!st.done);
        model_done = 1'b1;
        check_status(st, model_status(), "done after stop");
        axi_read(`REG_RESULT, data, resp);
        check_resp(resp, timer_pkg::OKAY, "RESULT read");
        check_result(data[`TIMER_WIDTH-1:0], timer_pkg::count_t'(t_stop - t_start), 2,
                     $sformatf("measurement %0d, gap %0d", n, gap));
        model_result = data[`TIMER_WIDTH-1:0];
        model_done   = 1'b0;
        check_idle_state("after RESULT read");
    endtask

    initial begin
        timer_pkg::axi_resp_e resp;
        logic [31:0]          data;
        int                   stamp;
        lfsr_q  = 16'd71;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        model_done    = 1'b0;
        model_running = 1'b0;
        model_result  = '0;
        repeat (16) @(posedge ext_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;

        check_idle_state("after reset");

        // Stop while idle is ignored
        axi_write(`REG_CTRL, 32'h2, resp, stamp);
        check_resp(resp, timer_pkg::OKAY, "idle stop write");
        wait_ext_until(stamp + 50);
        check_idle_state("idle stop");

        for (int i = 0; i < NUM_MEAS; i++) begin
            measure(i);
        end

        // Error responses leave everything untouched
        axi_write(`REG_STATUS, 32'h3, resp, stamp);
        check_resp(resp, timer_pkg::SLVERR, "STATUS write");
        axi_write(`REG_RESULT, 32'h1, resp, stamp);
        check_resp(resp, timer_pkg::SLVERR, "RESULT write");
        axi_write(4'hC, 32'h1, resp, stamp);
        check_resp(resp, timer_pkg::SLVERR, "unmapped write");
        axi_read(4'hC, data, resp);
        check_resp(resp, timer_pkg::SLVERR, "unmapped read");
        axi_read(`REG_CTRL, data, resp);
        check_resp(resp, timer_pkg::OKAY, "CTRL read");
        if (data != '0) mismatch("CTRL does not read as zero");
        wait_ext_until(stamp + 50);
        check_idle_state("after error accesses");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/timer_pkg.sv
rtl/timer_cdc_if.sv
rtl/timer_regs.sv
rtl/timer_core.sv
rtl/timer_top.sv
sim/tb_timer.sv

/* run.sh */
#!/bin/sh
# Compile and run the interval timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_timer -f tb.f -o sim_tb_timer
status=$?
if [ $status -ne 0 ]; then
    echo "Compilation failed with status $status"
    exit $status
fi

./obj_dir/sim_tb_timer
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished with status 0"
exit 0
